// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_fmc_board
FILE_LIST = src.f
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out=$$(./$(SIM_BIN) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// File: hw/board_gpio_sync.sv
// gpio bank to card pad mapping with synchronized pad readback

`include "fmc_defines.svh"

module board_gpio_sync
  import fmc_board_pkg::*;
(
  input  logic                       sys_clk_i,
  input  logic                       rst_n_i,

  input  logic [`FMC_GPIO_WIDTH-1:0] gpio_o_i,
  input  logic [`FMC_GPIO_WIDTH-1:0] gpio_t_i,
  output logic [`FMC_GPIO_WIDTH-1:0] gpio_i_o,

  input  logic [CTL_PAD_NUM-1:0]     ctl_pad_i,
  output logic [CTL_PAD_NUM-1:0]     ctl_pad_o,
  output logic [CTL_PAD_NUM-1:0]     ctl_pad_oe_o,
  input  logic [STAT_PAD_NUM-1:0]    stat_pad_i,
  output logic [STAT_PAD_NUM-1:0]    stat_pad_o,
  output logic [STAT_PAD_NUM-1:0]    stat_pad_oe_o,
  input  logic                       trig_i,
  input  logic [BD_PAD_NUM-1:0]      bd_pad_i,
  output logic [BD_PAD_NUM-1:0]      bd_pad_o,
  output logic [BD_PAD_NUM-1:0]      bd_pad_oe_o
);

  localparam int BANK_W = `FMC_GPIO_WIDTH / 2;
  localparam int SYNC_W = CTL_PAD_NUM + STAT_PAD_NUM + 1 + BD_PAD_NUM;

  logic [SYNC_W-1:0]       sync_q [`FMC_SYNC_STAGES];
  logic [CTL_PAD_NUM-1:0]  ctl_s;
  logic [STAT_PAD_NUM-1:0] stat_s;
  logic                    trig_s;
  logic [BD_PAD_NUM-1:0]   bd_s;

  gpio_bank_u              bank_o;
  gpio_bank_u              bank_t;
  gpio_bank_u              bank_i;
  gpio_bank_u              bank_chk;
  logic [BANK_W-1:0]       bank0_i;

  // ********************
  // pad drive, straight from the processor word

  assign bank_o.raw = gpio_o_i[`FMC_GPIO_WIDTH-1:BANK_W];
  assign bank_t.raw = gpio_t_i[`FMC_GPIO_WIDTH-1:BANK_W];

  always_comb begin
    ctl_pad_o[CTL_RST_0]        = bank_o.fld.rst_0;
    ctl_pad_o[CTL_PWDN_0]       = bank_o.fld.pwdn_0;
    ctl_pad_o[CTL_RST_1]        = bank_o.fld.rst_1;
    ctl_pad_o[CTL_PWDN_1]       = bank_o.fld.pwdn_1;
    ctl_pad_oe_o[CTL_RST_0]     = ~bank_t.fld.rst_0;
    ctl_pad_oe_o[CTL_PWDN_0]    = ~bank_t.fld.pwdn_0;
    ctl_pad_oe_o[CTL_RST_1]     = ~bank_t.fld.rst_1;
    ctl_pad_oe_o[CTL_PWDN_1]    = ~bank_t.fld.pwdn_1;

    stat_pad_o[STAT_IRQ_0]      = bank_o.fld.irq_0;
    stat_pad_o[STAT_FD_0]       = bank_o.fld.fd_0;
    stat_pad_o[STAT_IRQ_1]      = bank_o.fld.irq_1;
    stat_pad_o[STAT_FD_1]       = bank_o.fld.fd_1;
    stat_pad_o[STAT_PWR_GOOD]   = bank_o.fld.pwr_good;
    stat_pad_oe_o[STAT_IRQ_0]   = ~bank_t.fld.irq_0;
    stat_pad_oe_o[STAT_FD_0]    = ~bank_t.fld.fd_0;
    stat_pad_oe_o[STAT_IRQ_1]   = ~bank_t.fld.irq_1;
    stat_pad_oe_o[STAT_FD_1]    = ~bank_t.fld.fd_1;
    stat_pad_oe_o[STAT_PWR_GOOD] = ~bank_t.fld.pwr_good;
  end

  // carrier board pads sit in the lower bank
  assign bd_pad_o    = gpio_o_i[BD_PAD_NUM-1:0];
  assign bd_pad_oe_o = ~gpio_t_i[BD_PAD_NUM-1:0];

  // ********************
  // pad readback through the synchronizer

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `FMC_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= {ctl_pad_i, stat_pad_i, trig_i, bd_pad_i};
      for (int i = 1; i < `FMC_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign {ctl_s, stat_s, trig_s, bd_s} = sync_q[`FMC_SYNC_STAGES-1];

  always_comb begin
    bank_i.raw          = '0;
    bank_i.fld.rst_0    = ctl_s[CTL_RST_0];
    bank_i.fld.pwdn_0   = ctl_s[CTL_PWDN_0];
    bank_i.fld.rst_1    = ctl_s[CTL_RST_1];
    bank_i.fld.pwdn_1   = ctl_s[CTL_PWDN_1];
    bank_i.fld.irq_0    = stat_s[STAT_IRQ_0];
    bank_i.fld.fd_0     = stat_s[STAT_FD_0];
    bank_i.fld.irq_1    = stat_s[STAT_IRQ_1];
    bank_i.fld.fd_1     = stat_s[STAT_FD_1];
    bank_i.fld.pwr_good = stat_s[STAT_PWR_GOOD];
    bank_i.fld.trig     = trig_s;
    bank0_i                 = '0;
    bank0_i[BD_PAD_NUM-1:0] = bd_s;
  end

  assign gpio_i_o = {bank_i.raw, bank0_i};

  // reserved readback bits, both banks
  assign bank_chk.raw = gpio_i_o[`FMC_GPIO_WIDTH-1:BANK_W];

  a_rsvd_zero: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i)
    (bank_chk.fld.rsvd_hi == '0) && !bank_chk.fld.rsvd_13 &&
    (bank_chk.fld.rsvd_mid == '0) && (bank_chk.fld.rsvd_lo == '0) &&
    (gpio_i_o[BANK_W-1:BD_PAD_NUM] == '0));

endmodule

// File: hw/fmc_board_pkg.sv
// gpio bank 1 field union and pad index types for the fmc card pins

`include "fmc_defines.svh"

package fmc_board_pkg;

  localparam int CTL_PAD_NUM  = 4;
  localparam int STAT_PAD_NUM = 5;
  localparam int BD_PAD_NUM   = 21;

  // ********************
  // bank 1 fields, bit 0 of the bank is gpio bit 32
  typedef struct packed {
    logic [16:0] rsvd_hi;
    logic        trig;
    logic        rsvd_13;
    logic        pwr_good;
    logic        fd_1;
    logic        irq_1;
    logic        fd_0;
    logic        irq_0;
    logic        pwdn_1;
    logic        rst_1;
    logic [1:0]  rsvd_mid;
    logic        pwdn_0;
    logic        rst_0;
    logic [1:0]  rsvd_lo;
  } gpio_bank_fld_t;

  typedef union packed {
    logic [`FMC_GPIO_WIDTH/2-1:0] raw;
    gpio_bank_fld_t               fld;
  } gpio_bank_u;

  // positions inside the ctl and stat pad vectors
  typedef enum logic [1:0] {CTL_RST_0, CTL_PWDN_0, CTL_RST_1, CTL_PWDN_1} ctl_pad_e;
  typedef enum logic [2:0] {STAT_IRQ_0, STAT_FD_0, STAT_IRQ_1, STAT_FD_1, STAT_PWR_GOOD} stat_pad_e;

endpackage

// File: hw/fmc_board_top.sv
// fmc carrier glue top level with spi bridge, gpio pad block and sync fan-out

`include "fmc_defines.svh"

module fmc_board_top
  import fmc_board_pkg::*;
(
  input  logic                       sys_clk_i,
  input  logic                       rst_n_i,

  // host spi and converter sdio
  input  logic [`FMC_NUM_CS-1:0]     spi_csn_i,
  input  logic                       spi_clk_i,
  input  logic                       spi_mosi_i,
  output logic                       spi_miso_o,
  input  logic                       sdio_i,
  output logic                       sdio_o,
  output logic                       sdio_oe_o,
  output logic                       spi_dirn_o,
  output logic [1:0]                 adc_csn_o,
  output logic [1:0]                 dac_sync_o,
  output logic                       dac_clk_o,
  output logic                       dac_data_o,

  // processor gpio and card pads
  input  logic [`FMC_GPIO_WIDTH-1:0] gpio_o_i,
  input  logic [`FMC_GPIO_WIDTH-1:0] gpio_t_i,
  output logic [`FMC_GPIO_WIDTH-1:0] gpio_i_o,
  input  logic [CTL_PAD_NUM-1:0]     ctl_pad_i,
  output logic [CTL_PAD_NUM-1:0]     ctl_pad_o,
  output logic [CTL_PAD_NUM-1:0]     ctl_pad_oe_o,
  input  logic [STAT_PAD_NUM-1:0]    stat_pad_i,
  output logic [STAT_PAD_NUM-1:0]    stat_pad_o,
  output logic [STAT_PAD_NUM-1:0]    stat_pad_oe_o,
  input  logic                       trig_i,
  input  logic [BD_PAD_NUM-1:0]      bd_pad_i,
  output logic [BD_PAD_NUM-1:0]      bd_pad_o,
  output logic [BD_PAD_NUM-1:0]      bd_pad_oe_o,

  input  logic                       psync_i,
  output logic [1:0]                 psync_o
);

  // ********************
  // converter and clock dac spi

  spi_3wire_bridge u_spi_bridge (
    .sys_clk_i  (sys_clk_i),
    .rst_n_i    (rst_n_i),
    .spi_csn_i  (spi_csn_i),
    .spi_clk_i  (spi_clk_i),
    .spi_mosi_i (spi_mosi_i),
    .spi_miso_o (spi_miso_o),
    .sdio_i     (sdio_i),
    .sdio_o     (sdio_o),
    .sdio_oe_o  (sdio_oe_o),
    .spi_dirn_o (spi_dirn_o),
    .adc_csn_o  (adc_csn_o),
    .dac_sync_o (dac_sync_o),
    .dac_clk_o  (dac_clk_o),
    .dac_data_o (dac_data_o)
  );

  // ********************
  // card controls and board pads

  board_gpio_sync u_gpio (
    .sys_clk_i     (sys_clk_i),
    .rst_n_i       (rst_n_i),
    .gpio_o_i      (gpio_o_i),
    .gpio_t_i      (gpio_t_i),
    .gpio_i_o      (gpio_i_o),
    .ctl_pad_i     (ctl_pad_i),
    .ctl_pad_o     (ctl_pad_o),
    .ctl_pad_oe_o  (ctl_pad_oe_o),
    .stat_pad_i    (stat_pad_i),
    .stat_pad_o    (stat_pad_o),
    .stat_pad_oe_o (stat_pad_oe_o),
    .trig_i        (trig_i),
    .bd_pad_i      (bd_pad_i),
    .bd_pad_o      (bd_pad_o),
    .bd_pad_oe_o   (bd_pad_oe_o)
  );

  // same sync strobe to both converters
  assign psync_o = {2{psync_i}};

endmodule

// File: hw/fmc_defines.svh
// widths, chip select count and synchronizer depth for the fmc carrier glue

`ifndef FMC_DEFINES_SVH
`define FMC_DEFINES_SVH

// converter spi instruction, rd flag + width code + address
`define FMC_SPI_INSTR_BITS 16

// flops between a pad or spi pin and the sys_clk domain
`define FMC_SYNC_STAGES 2

// host spi chip selects, 0/1 converters, 2/3 clock dac
`define FMC_NUM_CS 4

// processor gpio word, bank 1 is the upper half
`define FMC_GPIO_WIDTH 64

`endif

// File: hw/spi_3w_pkg.sv
// spi instruction union and bit counter width for the 3-wire converter bridge

`include "fmc_defines.svh"

package spi_3w_pkg;

  // counter holds 0 .. instruction length
  localparam int SPI_CNT_W = $clog2(`FMC_SPI_INSTR_BITS + 1);

  // ********************
  // converter instruction header, msb first on the wire
  typedef struct packed {
    logic                            rd;
    logic [1:0]                      width;
    logic [`FMC_SPI_INSTR_BITS-4:0]  addr;
  } spi_instr_hdr_t;

  // raw view for shifting, hdr view for decode
  typedef union packed {
    logic [`FMC_SPI_INSTR_BITS-1:0]  raw;
    spi_instr_hdr_t                  hdr;
  } spi_instr_u;

endpackage

// File: hw/spi_3wire_bridge.sv
// spi to 3-wire sdio bridge with instruction decode, line turnaround and dac routing

`include "fmc_defines.svh"

module spi_3wire_bridge
  import spi_3w_pkg::*;
(
  input  logic                   sys_clk_i,
  input  logic                   rst_n_i,

  input  logic [`FMC_NUM_CS-1:0] spi_csn_i,
  input  logic                   spi_clk_i,
  input  logic                   spi_mosi_i,
  output logic                   spi_miso_o,

  input  logic                   sdio_i,
  output logic                   sdio_o,
  output logic                   sdio_oe_o,
  output logic                   spi_dirn_o,

  output logic [1:0]             adc_csn_o,
  output logic [1:0]             dac_sync_o,
  output logic                   dac_clk_o,
  output logic                   dac_data_o
);

  // {csn[1:0], clk, mosi, sdio}
  localparam int SYNC_W = 5;
  localparam logic [SYNC_W-1:0] SYNC_RST = 5'b11000;

  localparam logic [SPI_CNT_W-1:0] HDR_LAST = SPI_CNT_W'(`FMC_SPI_INSTR_BITS - 1);
  localparam logic [SPI_CNT_W-1:0] HDR_DONE = SPI_CNT_W'(`FMC_SPI_INSTR_BITS);

  logic [SYNC_W-1:0]    sync_q [`FMC_SYNC_STAGES];
  logic [1:0]           csn_s;
  logic                 clk_s;
  logic                 mosi_s;
  logic                 sdio_s;

  logic                 clk_d_q;
  logic                 clk_rise;
  logic                 conv_sel_s;
  logic                 conv_sel_raw;
  logic                 hdr_phase;

  logic [SPI_CNT_W-1:0] cnt_q;
  spi_instr_u           instr_q;
  spi_instr_u           instr_d;
  logic                 rd_phase_q;

  // ********************
  // input synchronizers

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `FMC_SYNC_STAGES; i++) begin
        sync_q[i] <= SYNC_RST;
      end
    end else begin
      sync_q[0] <= {spi_csn_i[1:0], spi_clk_i, spi_mosi_i, sdio_i};
      for (int i = 1; i < `FMC_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign {csn_s, clk_s, mosi_s, sdio_s} = sync_q[`FMC_SYNC_STAGES-1];

  assign clk_rise     = clk_s & ~clk_d_q;
  assign conv_sel_s   = ~&csn_s;
  assign conv_sel_raw = ~&spi_csn_i[1:0];
  assign hdr_phase    = (cnt_q != HDR_DONE);

  // ********************
  // instruction shift and decode

  // next word as it would look after this edge
  assign instr_d.raw = {instr_q.raw[`FMC_SPI_INSTR_BITS-2:0], mosi_s};

  always_ff @(posedge sys_clk_i) begin
    if (clk_rise && hdr_phase && conv_sel_s) begin
      instr_q <= instr_d;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      clk_d_q    <= 1'b0;
      cnt_q      <= '0;
      rd_phase_q <= 1'b0;
    end else begin
      clk_d_q <= clk_s;
      if (!conv_sel_s) begin
        // both converters released, back to idle
        cnt_q      <= '0;
        rd_phase_q <= 1'b0;
      end else if (clk_rise && hdr_phase) begin
        cnt_q <= cnt_q + 1'b1;
        // 16th edge, turn the line if the host asked for a read
        if (cnt_q == HDR_LAST) begin
          rd_phase_q <= instr_d.hdr.rd;
        end
      end
    end
  end

  // ********************
  // sdio direction and data

  assign sdio_o     = spi_mosi_i;
  assign sdio_oe_o  = conv_sel_raw & ~rd_phase_q;
  assign spi_dirn_o = ~rd_phase_q;
  assign spi_miso_o = rd_phase_q & sdio_s;

  // chip select and clock dac routing
  assign adc_csn_o  = spi_csn_i[1:0];
  assign dac_sync_o = spi_csn_i[3:2];
  assign dac_clk_o  = spi_clk_i;
  assign dac_data_o = spi_mosi_i;

  // ********************
  // checks

  // read phase drops once the deselect has been seen
  a_rd_release: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i)
    (!conv_sel_s ##1 !conv_sel_s) |-> !rd_phase_q);

  a_cnt_range: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i)
    !rd_phase_q |-> (cnt_q <= HDR_DONE));

endmodule

// File: src.f
+incdir+hw
hw/spi_3w_pkg.sv
hw/fmc_board_pkg.sv
hw/spi_3wire_bridge.sv
hw/board_gpio_sync.sv
hw/fmc_board_top.sv
verif/tb_fmc_board.sv

// File: verif/tb_fmc_board.sv
// testbench for the fmc carrier glue: spi bit-bang, gpio pad table, sync fan-out and timeout

`include "fmc_defines.svh"

module tb_fmc_board
  import spi_3w_pkg::*, fmc_board_pkg::*;
();

  typedef struct {
    int unsigned                    cs;
    logic                           rd;
    logic [1:0]                     width;
    logic [`FMC_SPI_INSTR_BITS-4:0] addr;
    logic [7:0]                     wr;
    logic [7:0]                     reply;
    logic [7:0]                     exp;
  } spi_row_t;

  typedef struct {
    logic [31:0] bank_o;
    logic [31:0] bank_t;
    logic [3:0]  ctl;
    logic [4:0]  stat;
    logic        trig;
    gpio_bank_u  exp;
  } gpio_row_t;

  localparam int NUM_SPI_FIXED  = 6;
  localparam int NUM_SPI        = 10;
  localparam int NUM_GPIO_FIXED = 4;
  localparam int NUM_GPIO       = 10;
  localparam int XFER_BITS      = `FMC_SPI_INSTR_BITS + 8;
  localparam int TIMEOUT_CYCLES = NUM_SPI * XFER_BITS * 8 + NUM_GPIO * 8 + 200;
  // bank bits that reach a ctl or stat pad
  localparam logic [31:0] FIELD_MASK = 32'h0000_1fcc;

  logic                       sys_clk_i;
  logic                       rst_n_i;
  logic [`FMC_NUM_CS-1:0]     spi_csn_i;
  logic                       spi_clk_i;
  logic                       spi_mosi_i;
  logic                       spi_miso_o;
  logic                       sdio_i;
  logic                       sdio_o;
  logic                       sdio_oe_o;
  logic                       spi_dirn_o;
  logic [1:0]                 adc_csn_o;
  logic [1:0]                 dac_sync_o;
  logic                       dac_clk_o;
  logic                       dac_data_o;
  logic [`FMC_GPIO_WIDTH-1:0] gpio_o_i;
  logic [`FMC_GPIO_WIDTH-1:0] gpio_t_i;
  logic [`FMC_GPIO_WIDTH-1:0] gpio_i_o;
  logic [CTL_PAD_NUM-1:0]     ctl_pad_i;
  logic [CTL_PAD_NUM-1:0]     ctl_pad_o;
  logic [CTL_PAD_NUM-1:0]     ctl_pad_oe_o;
  logic [STAT_PAD_NUM-1:0]    stat_pad_i;
  logic [STAT_PAD_NUM-1:0]    stat_pad_o;
  logic [STAT_PAD_NUM-1:0]    stat_pad_oe_o;
  logic                       trig_i;
  logic [BD_PAD_NUM-1:0]      bd_pad_i;
  logic [BD_PAD_NUM-1:0]      bd_pad_o;
  logic [BD_PAD_NUM-1:0]      bd_pad_oe_o;
  logic                       psync_i;
  logic [1:0]                 psync_o;

  spi_row_t    spi_rows [NUM_SPI];
  gpio_row_t   gpio_rows [NUM_GPIO];
  integer      seed = 32'h3c67_da18;
  int unsigned cycles = 0;

  fmc_board_top dut0 (.*);

  initial begin
    sys_clk_i = 1'b0;
    forever #2 sys_clk_i = ~sys_clk_i;
  end

  // ********************
  // failure reporting and compare tasks

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_line(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bank(input string name, input gpio_bank_u got, input gpio_bank_u exp);
    if (got.raw !== exp.raw) begin
      stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got.raw, exp.raw));
    end
  endtask

  always @(posedge sys_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("timeout, tests still running after %0d cycles", cycles));
    end
  end

  // pad vectors placed at their bank field positions
  function automatic gpio_bank_u pads_to_bank(input logic [3:0] ctl, input logic [4:0] stat,
                                              input logic trig);
    gpio_bank_u b;
    b.raw          = '0;
    b.fld.rst_0    = ctl[CTL_RST_0];
    b.fld.pwdn_0   = ctl[CTL_PWDN_0];
    b.fld.rst_1    = ctl[CTL_RST_1];
    b.fld.pwdn_1   = ctl[CTL_PWDN_1];
    b.fld.irq_0    = stat[STAT_IRQ_0];
    b.fld.fd_0     = stat[STAT_FD_0];
    b.fld.irq_1    = stat[STAT_IRQ_1];
    b.fld.fd_1     = stat[STAT_FD_1];
    b.fld.pwr_good = stat[STAT_PWR_GOOD];
    b.fld.trig     = trig;
    return b;
  endfunction

  task automatic check_readback(input gpio_bank_u exp_hi, input logic [31:0] exp_lo);
    gpio_bank_u got;
    got.raw = gpio_i_o[63:32];
    check_bank("gpio_i_o[63:32]", got, exp_hi);
    for (int i = 0; i < 32; i++) begin
      check_line($sformatf("gpio_i_o[%0d]", i), gpio_i_o[i], exp_lo[i]);
    end
  endtask

  // ********************
  // spi bit-bang, mode 0, 4 sys cycles per half period

  task automatic spi_transfer(input spi_row_t row);
    spi_instr_u              instr;
    logic [XFER_BITS-1:0]    word;
    logic [XFER_BITS-1:0]    sword;
    logic [`FMC_NUM_CS-1:0]  csn;
    logic [3:0]              cs_out;
    logic                    conv;
    logic                    turned;
    logic [7:0]              cap;
    instr.hdr.rd    = row.rd;
    instr.hdr.width = row.width;
    instr.hdr.addr  = row.addr;
    word  = {instr.raw, row.wr};
    sword = {{`FMC_SPI_INSTR_BITS{1'b0}}, row.reply};
    csn   = ~(4'b0001 << row.cs);
    conv  = (row.cs < 2);
    cap   = '0;
    spi_csn_i <= csn;
    spi_clk_i <= 1'b0;
    repeat (4) @(posedge sys_clk_i);
    for (int i = 0; i < XFER_BITS; i++) begin
      spi_mosi_i <= word[XFER_BITS-1-i];
      sdio_i     <= sword[XFER_BITS-1-i];
      spi_clk_i  <= 1'b0;
      repeat (4) @(posedge sys_clk_i);
      spi_clk_i <= 1'b1;
      repeat (3) @(posedge sys_clk_i);
      // sample late in the high half, ahead of the next falling edge
      @(negedge sys_clk_i);
      turned = conv && row.rd && (i >= `FMC_SPI_INSTR_BITS - 1);
      check_line("sdio_oe_o", sdio_oe_o, conv && !turned);
      check_line("spi_dirn_o", spi_dirn_o, !turned);
      if (!turned) begin
        check_line("spi_miso_o", spi_miso_o, 1'b0);
      end
      if (conv && !turned) begin
        check_line("sdio_o", sdio_o, word[XFER_BITS-1-i]);
      end
      if (i >= `FMC_SPI_INSTR_BITS) begin
        cap = {cap[6:0], spi_miso_o};
      end
      cs_out = {dac_sync_o, adc_csn_o};
      for (int k = 0; k < 4; k++) begin
        check_line($sformatf("chip select route bit %0d", k), cs_out[k], csn[k]);
      end
      check_line("dac_clk_o", dac_clk_o, 1'b1);
      check_line("dac_data_o", dac_data_o, word[XFER_BITS-1-i]);
      @(posedge sys_clk_i);
    end
    spi_clk_i <= 1'b0;
    spi_csn_i <= '1;
    sdio_i    <= 1'b0;
    repeat (2 + `FMC_SYNC_STAGES) @(posedge sys_clk_i);
    @(negedge sys_clk_i);
    check_line("sdio_oe_o after deselect", sdio_oe_o, 1'b0);
    check_line("spi_dirn_o after deselect", spi_dirn_o, 1'b1);
    check_line("dac_clk_o after deselect", dac_clk_o, 1'b0);
    check_byte("captured miso byte", cap, row.exp);
    @(posedge sys_clk_i);
  endtask

  // ********************
  // gpio pad drive and readback

  task automatic gpio_apply(input gpio_row_t row);
    gpio_bank_u            exp_pad;
    logic [31:0]           lo_o;
    logic [31:0]           lo_t;
    logic [BD_PAD_NUM-1:0] bd_in;
    lo_o  = $random(seed);
    lo_t  = $random(seed);
    bd_in = BD_PAD_NUM'($random(seed));
    gpio_o_i   <= {row.bank_o, lo_o};
    gpio_t_i   <= {row.bank_t, lo_t};
    ctl_pad_i  <= row.ctl;
    stat_pad_i <= row.stat;
    trig_i     <= row.trig;
    bd_pad_i   <= bd_in;
    @(negedge sys_clk_i);
    exp_pad.raw = row.bank_o & FIELD_MASK;
    check_bank("ctl/stat pad_o", pads_to_bank(ctl_pad_o, stat_pad_o, 1'b0), exp_pad);
    exp_pad.raw = ~row.bank_t & FIELD_MASK;
    check_bank("ctl/stat pad_oe_o", pads_to_bank(ctl_pad_oe_o, stat_pad_oe_o, 1'b0), exp_pad);
    for (int i = 0; i < BD_PAD_NUM; i++) begin
      check_line($sformatf("bd_pad_o[%0d]", i), bd_pad_o[i], lo_o[i]);
      check_line($sformatf("bd_pad_oe_o[%0d]", i), bd_pad_oe_o[i], ~lo_t[i]);
    end
    repeat (4) @(posedge sys_clk_i);
    @(negedge sys_clk_i);
    check_readback(row.exp, {11'h000, bd_in});
    @(posedge sys_clk_i);
  endtask

  // ********************
  // main sequence

  initial begin
    gpio_bank_u zero_bank;
    logic       ps;
    rst_n_i    = 1'b0;
    spi_csn_i  = '1;
    spi_clk_i  = 1'b0;
    spi_mosi_i = 1'b0;
    sdio_i     = 1'b0;
    gpio_o_i   = '0;
    gpio_t_i   = '1;
    ctl_pad_i  = '0;
    stat_pad_i = '0;
    trig_i     = 1'b0;
    bd_pad_i   = '0;
    psync_i    = 1'b0;
    zero_bank.raw = '0;

    // cs, rd, width, addr, write byte, reply byte, captured byte
    spi_rows[0] = '{0, 1'b0, 2'd0, 13'h0014, 8'ha5, 8'h00, 8'h00};
    spi_rows[1] = '{1, 1'b1, 2'd0, 13'h0001, 8'h00, 8'h3c, 8'h3c};
    spi_rows[2] = '{0, 1'b1, 2'd3, 13'h1fff, 8'h00, 8'hc3, 8'hc3};
    spi_rows[3] = '{2, 1'b0, 2'd1, 13'h0100, 8'h5a, 8'h00, 8'h00};
    // clock dac select with the read flag set, no turnaround
    spi_rows[4] = '{3, 1'b1, 2'd0, 13'h0002, 8'h00, 8'hff, 8'h00};
    spi_rows[5] = '{1, 1'b0, 2'd1, 13'h0aaa, 8'hff, 8'h81, 8'h00};
    for (int r = NUM_SPI_FIXED; r < NUM_SPI; r++) begin
      spi_rows[r].cs    = $unsigned($random(seed)) % 4;
      spi_rows[r].rd    = 1'($random(seed));
      spi_rows[r].width = 2'($random(seed));
      spi_rows[r].addr  = 13'($random(seed));
      spi_rows[r].wr    = 8'($random(seed));
      spi_rows[r].reply = 8'($random(seed));
      spi_rows[r].exp   = (spi_rows[r].cs < 2 && spi_rows[r].rd) ? spi_rows[r].reply : 8'h00;
    end

    // bank word, tristate word, ctl pads, stat pads, trig, expected bank readback
    gpio_rows[0] = '{32'h0000_5fcc, 32'h0000_0000, 4'b0101, 5'b10011, 1'b1, 32'h0000_5344};
    gpio_rows[1] = '{32'hffff_ffff, 32'h0000_1fcc, 4'b1010, 5'b01100, 1'b0, 32'h0000_0c88};
    gpio_rows[2] = '{32'h1234_0044, 32'hffff_0000, 4'b1111, 5'b11111, 1'b1, 32'h0000_5fcc};
    gpio_rows[3] = '{32'h0000_0000, 32'hffff_ffff, 4'b0000, 5'b00000, 1'b0, 32'h0000_0000};
    for (int r = NUM_GPIO_FIXED; r < NUM_GPIO; r++) begin
      gpio_rows[r].bank_o = $random(seed);
      gpio_rows[r].bank_t = $random(seed);
      gpio_rows[r].ctl    = 4'($random(seed));
      gpio_rows[r].stat   = 5'($random(seed));
      gpio_rows[r].trig   = 1'($random(seed));
      gpio_rows[r].exp    = pads_to_bank(gpio_rows[r].ctl, gpio_rows[r].stat, gpio_rows[r].trig);
    end

    repeat (3) @(posedge sys_clk_i);
    rst_n_i <= 1'b1;
    @(negedge sys_clk_i);
    check_line("spi_dirn_o at reset", spi_dirn_o, 1'b1);
    check_line("sdio_oe_o at reset", sdio_oe_o, 1'b0);
    check_line("spi_miso_o at reset", spi_miso_o, 1'b0);
    check_readback(zero_bank, 32'h0);
    @(posedge sys_clk_i);

    for (int r = 0; r < NUM_SPI; r++) begin
      spi_transfer(spi_rows[r]);
    end
    for (int r = 0; r < NUM_GPIO; r++) begin
      gpio_apply(gpio_rows[r]);
    end

    // sync strobe reaches both converters in the same cycle
    for (int n = 0; n < 4; n++) begin
      ps = 1'(n);
      psync_i <= ps;
      @(negedge sys_clk_i);
      check_line("psync_o[0]", psync_o[0], ps);
      check_line("psync_o[1]", psync_o[1], ps);
      @(posedge sys_clk_i);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule
